// File: id_pkg.sv
package id_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // major opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;

    // function field of special instructions
    localparam logic [5:0] func_and  = 6'b100100;
    localparam logic [5:0] func_or   = 6'b100101;
    localparam logic [5:0] func_xor  = 6'b100110;
    localparam logic [5:0] func_nor  = 6'b100111;
    localparam logic [5:0] func_sll  = 6'b000000;
    localparam logic [5:0] func_srl  = 6'b000010;
    localparam logic [5:0] func_sra  = 6'b000011;
    localparam logic [5:0] func_sllv = 6'b000100;
    localparam logic [5:0] func_srlv = 6'b000110;
    localparam logic [5:0] func_srav = 6'b000111;
    localparam logic [5:0] func_sync = 6'b001111;
    localparam logic [5:0] func_add  = 6'b100000;
    localparam logic [5:0] func_addu = 6'b100001;
    localparam logic [5:0] func_sub  = 6'b100010;
    localparam logic [5:0] func_subu = 6'b100011;
    localparam logic [5:0] func_slt  = 6'b101010;
    localparam logic [5:0] func_sltu = 6'b101011;
    // same code as sll, nop is the all-zero word
    localparam logic [5:0] func_nop  = func_sll;

    // result class
    localparam logic [2:0] res_nop   = 3'b000;
    localparam logic [2:0] res_logic = 3'b001;
    localparam logic [2:0] res_shift = 3'b010;
    localparam logic [2:0] res_arith = 3'b100;

    // operation codes handed to execute
    localparam logic [7:0] alu_nop  = 8'b00000000;
    localparam logic [7:0] alu_and  = 8'b00100100;
    localparam logic [7:0] alu_or   = 8'b00100101;
    localparam logic [7:0] alu_xor  = 8'b00100110;
    localparam logic [7:0] alu_nor  = 8'b00100111;
    localparam logic [7:0] alu_sll  = 8'b01111100;
    localparam logic [7:0] alu_srl  = 8'b00000010;
    localparam logic [7:0] alu_sra  = 8'b00000011;
    localparam logic [7:0] alu_add  = 8'b00100000;
    localparam logic [7:0] alu_addu = 8'b00100001;
    localparam logic [7:0] alu_sub  = 8'b00100010;
    localparam logic [7:0] alu_subu = 8'b00100011;
    localparam logic [7:0] alu_slt  = 8'b00101010;
    localparam logic [7:0] alu_sltu = 8'b00101011;

    // one instruction word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            func;
        } r_view;
        struct packed {
            logic [5:0]            op;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0]           imm16;
        } i_view;
    } inst_u;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic [2:0]            alusel;
        logic [7:0]            aluop;
        logic [reg_addr_w-1:0] waddr;
        logic                  wreg;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t              ctrl;
        logic [data_w-1:0]     reg1_data;
        logic [data_w-1:0]     reg2_data;
    } id_ex_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [data_w-1:0]     data;
    } wb_t;

endpackage

// File: inst_decoder.sv
module inst_decoder (
    input  id_pkg::inst_u             inst_i,
    output id_pkg::id_ctrl_t          ctrl_o,
    output id_pkg::rd_req_t           rd1_o,
    output id_pkg::rd_req_t           rd2_o,
    output logic [id_pkg::data_w-1:0] imm_o,
    output logic                      invalid_o
);

    logic [5:0]                    op;
    logic [5:0]                    func;
    logic [id_pkg::reg_addr_w-1:0] rs;
    logic [id_pkg::reg_addr_w-1:0] rt;
    logic [id_pkg::reg_addr_w-1:0] rd;
    logic [4:0]                    shamt;
    logic [15:0]                   imm16;
    logic                          shamt_ok;
    logic                          is_nop;

    // instruction form picked by the decode
    logic                          reg_form;
    logic                          imm_form;
    logic                          shift_imm;
    logic                          shift_var;
    logic                          no_op;
    logic [2:0]                    alusel;
    logic [7:0]                    aluop;
    logic [id_pkg::data_w-1:0]     ext_imm;

    assign op    = inst_i.r_view.op;
    assign func  = inst_i.r_view.func;
    assign rs    = inst_i.r_view.rs;
    assign rt    = inst_i.r_view.rt;
    assign rd    = inst_i.r_view.rd;
    assign shamt = inst_i.r_view.shamt;
    assign imm16 = inst_i.i_view.imm16;

    assign shamt_ok = (shamt == '0);
    // sll r0, r0, 0
    assign is_nop   = (op == id_pkg::op_special) && (func == id_pkg::func_nop) &&
                      ({rs, rt, rd, shamt} == '0);

    // operation code
    always_comb begin
        aluop = id_pkg::alu_nop;
        if (op == id_pkg::op_special) begin
            case (func)
                id_pkg::func_and:  aluop = id_pkg::alu_and;
                id_pkg::func_or:   aluop = id_pkg::alu_or;
                id_pkg::func_xor:  aluop = id_pkg::alu_xor;
                id_pkg::func_nor:  aluop = id_pkg::alu_nor;
                id_pkg::func_sll,
                id_pkg::func_sllv: aluop = id_pkg::alu_sll;
                id_pkg::func_srl,
                id_pkg::func_srlv: aluop = id_pkg::alu_srl;
                id_pkg::func_sra,
                id_pkg::func_srav: aluop = id_pkg::alu_sra;
                id_pkg::func_add:  aluop = id_pkg::alu_add;
                id_pkg::func_addu: aluop = id_pkg::alu_addu;
                id_pkg::func_sub:  aluop = id_pkg::alu_sub;
                id_pkg::func_subu: aluop = id_pkg::alu_subu;
                id_pkg::func_slt:  aluop = id_pkg::alu_slt;
                id_pkg::func_sltu: aluop = id_pkg::alu_sltu;
                default:           aluop = id_pkg::alu_nop;
            endcase
        end else begin
            case (op)
                id_pkg::op_andi:   aluop = id_pkg::alu_and;
                // lui is an or with r0
                id_pkg::op_ori,
                id_pkg::op_lui:    aluop = id_pkg::alu_or;
                id_pkg::op_xori:   aluop = id_pkg::alu_xor;
                id_pkg::op_addi:   aluop = id_pkg::alu_add;
                id_pkg::op_addiu:  aluop = id_pkg::alu_addu;
                id_pkg::op_slti:   aluop = id_pkg::alu_slt;
                id_pkg::op_sltiu:  aluop = id_pkg::alu_sltu;
                default:           aluop = id_pkg::alu_nop;
            endcase
        end
    end

    // result class, form and extended immediate
    always_comb begin
        alusel    = id_pkg::res_nop;
        reg_form  = 1'b0;
        imm_form  = 1'b0;
        shift_imm = 1'b0;
        shift_var = 1'b0;
        no_op     = 1'b0;
        ext_imm   = '0;
        case (op)
            id_pkg::op_special: begin
                case (func)
                    id_pkg::func_and, id_pkg::func_or,
                    id_pkg::func_xor, id_pkg::func_nor: begin
                        alusel   = id_pkg::res_logic;
                        reg_form = shamt_ok;
                    end
                    id_pkg::func_add, id_pkg::func_addu, id_pkg::func_sub,
                    id_pkg::func_subu, id_pkg::func_slt, id_pkg::func_sltu: begin
                        alusel   = id_pkg::res_arith;
                        reg_form = shamt_ok;
                    end
                    id_pkg::func_sll, id_pkg::func_srl, id_pkg::func_sra: begin
                        alusel    = id_pkg::res_shift;
                        shift_imm = !is_nop;
                        no_op     = is_nop;
                    end
                    id_pkg::func_sllv, id_pkg::func_srlv, id_pkg::func_srav: begin
                        alusel    = id_pkg::res_shift;
                        shift_var = shamt_ok;
                    end
                    // memory ordering only, nothing to do here
                    id_pkg::func_sync: no_op = shamt_ok;
                    default:           no_op = 1'b0;
                endcase
            end
            id_pkg::op_andi, id_pkg::op_ori, id_pkg::op_xori: begin
                alusel   = id_pkg::res_logic;
                imm_form = 1'b1;
                ext_imm  = {{(id_pkg::data_w-16){1'b0}}, imm16};
            end
            id_pkg::op_lui: begin
                alusel   = id_pkg::res_logic;
                imm_form = 1'b1;
                ext_imm  = {imm16, {(id_pkg::data_w-16){1'b0}}};
            end
            id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu: begin
                alusel   = id_pkg::res_arith;
                imm_form = 1'b1;
                ext_imm  = {{(id_pkg::data_w-16){imm16[15]}}, imm16};
            end
            default: imm_form = 1'b0;
        endcase
    end

    // read requests, destination and write enable
    always_comb begin
        ctrl_o    = '0;
        rd1_o     = '0;
        rd2_o     = '0;
        imm_o     = '0;
        invalid_o = 1'b0;
        if (reg_form) begin
            rd1_o        = '{en: 1'b1, addr: rs};
            rd2_o        = '{en: 1'b1, addr: rt};
            ctrl_o.waddr = rd;
        end else if (shift_var) begin
            // value from rt, amount from rs
            rd1_o        = '{en: 1'b1, addr: rt};
            rd2_o        = '{en: 1'b1, addr: rs};
            ctrl_o.waddr = rd;
        end else if (shift_imm) begin
            rd1_o        = '{en: 1'b1, addr: rt};
            imm_o        = {{(id_pkg::data_w-5){1'b0}}, shamt};
            ctrl_o.waddr = rd;
        end else if (imm_form) begin
            rd1_o        = '{en: 1'b1, addr: rs};
            imm_o        = ext_imm;
            ctrl_o.waddr = rt;
        end else begin
            invalid_o = !no_op;
        end

        if (reg_form || shift_var || shift_imm || imm_form) begin
            ctrl_o.alusel = alusel;
            ctrl_o.aluop  = aluop;
            ctrl_o.wreg   = 1'b1;
        end

        // a rejected word never reaches the register file
        assert (!(invalid_o && (rd1_o.en || rd2_o.en)))
            else $error("read request raised for an invalid instruction");
    end

endmodule

// File: operand_sel.sv
module operand_sel (
    input  id_pkg::rd_req_t           rd1_i,
    input  id_pkg::rd_req_t           rd2_i,
    input  logic [id_pkg::data_w-1:0] rdata1_i,
    input  logic [id_pkg::data_w-1:0] rdata2_i,
    input  logic [id_pkg::data_w-1:0] imm_i,
    output logic [id_pkg::data_w-1:0] op1_o,
    output logic [id_pkg::data_w-1:0] op2_o
);

    always_comb begin
        if (rd1_i.en) begin
            op1_o = rdata1_i;
        end else begin
            op1_o = '0;
        end
    end

    // operand 2 falls back to the immediate
    always_comb begin
        if (rd2_i.en) begin
            op2_o = rdata2_i;
        end else begin
            op2_o = imm_i;
        end
    end

endmodule

// File: regfile.sv
module regfile (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  id_pkg::wb_t               wb_i,
    input  id_pkg::rd_req_t           rd1_i,
    input  id_pkg::rd_req_t           rd2_i,
    output logic [id_pkg::data_w-1:0] rdata1_o,
    output logic [id_pkg::data_w-1:0] rdata2_o
);

    logic [id_pkg::data_w-1:0] regs [id_pkg::reg_count];

    // r0 is never written
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < id_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // one read port with write-through of the pending write
    function automatic logic [id_pkg::data_w-1:0] read_port(input id_pkg::rd_req_t req);
        logic [id_pkg::data_w-1:0] value;
        if (!req.en || (req.addr == '0)) begin
            value = '0;
        end else if (wb_i.we && (wb_i.addr == req.addr)) begin
            value = wb_i.data;
        end else begin
            value = regs[req.addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata1_o = read_port(rd1_i);
    end

    always_comb begin
        rdata2_o = read_port(rd2_i);
    end

    // r0 stays zero even while it is the write target
    assert property (@(posedge clk) disable iff (!arst_n_i)
        ((rd1_i.addr != '0) || (rdata1_o == '0)) &&
        ((rd2_i.addr != '0) || (rdata2_o == '0)))
        else $error("nonzero data read from r0");

endmodule

// File: id_ex_reg.sv
module id_ex_reg (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  id_pkg::id_ctrl_t          ctrl_i,
    input  logic [id_pkg::data_w-1:0] op1_i,
    input  logic [id_pkg::data_w-1:0] op2_i,
    input  logic                      invalid_i,
    output id_pkg::id_ex_t            id_ex_o,
    output logic                      inst_invalid_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o        <= '0;
            inst_invalid_o <= 1'b0;
        end else if (invalid_i) begin
            // bubble in place of the rejected word
            id_ex_o        <= '0;
            inst_invalid_o <= 1'b1;
        end else begin
            id_ex_o.ctrl      <= ctrl_i;
            id_ex_o.reg1_data <= op1_i;
            id_ex_o.reg2_data <= op2_i;
            inst_invalid_o    <= 1'b0;
        end
    end

    // an invalid word never writes back and is flagged for exactly its cycle
    assert property (@(posedge clk) disable iff (!arst_n_i)
        invalid_i |=> (!id_ex_o.ctrl.wreg && inst_invalid_o))
        else $error("invalid instruction left a register write in id_ex");

endmodule

// File: id_stage.sv
module id_stage (
    input  logic           clk,
    input  logic           arst_n_i,
    input  id_pkg::inst_u  inst_i,
    input  id_pkg::wb_t    wb_i,
    output id_pkg::id_ex_t id_ex_o,
    output logic           inst_invalid_o
);

    id_pkg::id_ctrl_t          ctrl;
    id_pkg::rd_req_t           rd1;
    id_pkg::rd_req_t           rd2;
    logic [id_pkg::data_w-1:0] imm;
    logic [id_pkg::data_w-1:0] rdata1;
    logic [id_pkg::data_w-1:0] rdata2;
    logic [id_pkg::data_w-1:0] op1;
    logic [id_pkg::data_w-1:0] op2;
    logic                      invalid;

    inst_decoder u_decoder (
        .inst_i    (inst_i),
        .ctrl_o    (ctrl),
        .rd1_o     (rd1),
        .rd2_o     (rd2),
        .imm_o     (imm),
        .invalid_o (invalid)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_i),
        .rd1_i    (rd1),
        .rd2_i    (rd2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_sel u_operand_sel (
        .rd1_i    (rd1),
        .rd2_i    (rd2),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .imm_i    (imm),
        .op1_o    (op1),
        .op2_o    (op2)
    );

    // decode/execute boundary
    id_ex_reg u_id_ex_reg (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ctrl_i         (ctrl),
        .op1_i          (op1),
        .op2_i          (op2),
        .invalid_i      (invalid),
        .id_ex_o        (id_ex_o),
        .inst_invalid_o (inst_invalid_o)
    );

endmodule

// File: tb_id_tasks.svh
`ifndef TB_ID_TASKS_SVH
`define TB_ID_TASKS_SVH

localparam id_pkg::wb_t    wb_idle      = '0;
localparam id_pkg::id_ex_t empty_bundle = '0;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic id_pkg::inst_u r_type_word(input logic [5:0] func, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd,
                                              input logic [4:0] shamt);
    id_pkg::inst_u w;
    w = {id_pkg::op_special, rs, rt, rd, shamt, func};
    return w;
endfunction

function automatic id_pkg::inst_u i_type_word(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm16);
    id_pkg::inst_u w;
    w = {op, rs, rt, imm16};
    return w;
endfunction

// shadow register file with r0 hardwired
function automatic logic [31:0] reg_value(input logic [4:0] addr);
    logic [31:0] v;
    v = (addr == 5'd0) ? 32'd0 : shadow[addr];
    return v;
endfunction

function automatic id_pkg::id_ex_t expected_bundle(input logic [2:0] alusel,
                                                   input logic [7:0] aluop,
                                                   input logic [4:0] waddr,
                                                   input logic [31:0] op1,
                                                   input logic [31:0] op2);
    id_pkg::id_ex_t b;
    b.ctrl.alusel = alusel;
    b.ctrl.aluop  = aluop;
    b.ctrl.waddr  = waddr;
    b.ctrl.wreg   = 1'b1;
    b.reg1_data   = op1;
    b.reg2_data   = op2;
    return b;
endfunction

task automatic fail_run();
    $display("Test failed");
    $fatal(1);
endtask

task automatic check_id_ex(input id_pkg::id_ex_t got, input id_pkg::id_ex_t exp,
                           input string what);
    if (got !== exp) begin
        $display("mismatch at %0t: id_ex_o (%s) got %h expected %h", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        fail_run();
    end
endtask

// called on a falling edge, returns on the next one with the bundle latched
task automatic issue(input id_pkg::inst_u inst, input id_pkg::wb_t wb);
    inst_i = inst;
    wb_i   = wb;
    @(negedge clk);
    wb_i.we = 1'b0;
endtask

task automatic write_reg(input logic [4:0] waddr, input logic [31:0] wdata);
    issue('0, '{we: 1'b1, addr: waddr, data: wdata});
    if (waddr != 5'd0) begin
        shadow[waddr] = wdata;
    end
endtask

task automatic fill_registers();
    for (int a = 1; a < id_pkg::reg_count; a++) begin
        rng_state = xorshift32(rng_state);
        write_reg(5'(a), rng_state);
    end
endtask

task automatic reset_values();
    check_id_ex(id_ex_o, empty_bundle, "after reset");
    check_bit(inst_invalid_o, 1'b0, "inst_invalid_o");
endtask

task automatic reg_form_ops();
    logic [5:0] funcs [10];
    logic [7:0] ops [10];
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [2:0] cls;
    funcs = '{id_pkg::func_and, id_pkg::func_or, id_pkg::func_xor, id_pkg::func_nor,
              id_pkg::func_add, id_pkg::func_addu, id_pkg::func_sub, id_pkg::func_subu,
              id_pkg::func_slt, id_pkg::func_sltu};
    ops = '{id_pkg::alu_and, id_pkg::alu_or, id_pkg::alu_xor, id_pkg::alu_nor,
            id_pkg::alu_add, id_pkg::alu_addu, id_pkg::alu_sub, id_pkg::alu_subu,
            id_pkg::alu_slt, id_pkg::alu_sltu};
    for (int i = 0; i < 10; i++) begin
        rs  = 5'(i + 1);
        rt  = 5'(30 - 2 * i);
        rd  = 5'(3 * i + 2);
        cls = (i < 4) ? id_pkg::res_logic : id_pkg::res_arith;
        issue(r_type_word(funcs[i], rs, rt, rd, 5'd0), wb_idle);
        check_id_ex(id_ex_o, expected_bundle(cls, ops[i], rd, reg_value(rs), reg_value(rt)),
                    "register form");
        check_bit(inst_invalid_o, 1'b0, "inst_invalid_o");
    end
    // r0 on either side reads as zero
    issue(r_type_word(id_pkg::func_or, 5'd0, 5'd17, 5'd5, 5'd0), wb_idle);
    check_id_ex(id_ex_o, expected_bundle(id_pkg::res_logic, id_pkg::alu_or, 5'd5, 32'd0,
                reg_value(5'd17)), "or with rs r0");
    issue(r_type_word(id_pkg::func_sub, 5'd21, 5'd0, 5'd9, 5'd0), wb_idle);
    check_id_ex(id_ex_o, expected_bundle(id_pkg::res_arith, id_pkg::alu_sub, 5'd9,
                reg_value(5'd21), 32'd0), "sub with rt r0");
endtask

task automatic imm_form_ops();
    logic [5:0]  opcodes [8];
    logic [7:0]  alu [8];
    logic [15:0] imms [2];
    logic [31:0] ext;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [2:0]  cls;
    opcodes = '{id_pkg::op_andi, id_pkg::op_ori, id_pkg::op_xori, id_pkg::op_lui,
                id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu};
    alu = '{id_pkg::alu_and, id_pkg::alu_or, id_pkg::alu_xor, id_pkg::alu_or,
            id_pkg::alu_add, id_pkg::alu_addu, id_pkg::alu_slt, id_pkg::alu_sltu};
    // positive and negative imm16
    imms = '{16'h7a35, 16'h8c01};
    for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 2; j++) begin
            rs  = (i == 3) ? 5'd0 : 5'(i + 4);
            rt  = 5'(i + 12);
            cls = (i < 4) ? id_pkg::res_logic : id_pkg::res_arith;
            if (i < 3) begin
                ext = {16'h0000, imms[j]};
            end else if (i == 3) begin
                ext = {imms[j], 16'h0000};
            end else begin
                ext = {{16{imms[j][15]}}, imms[j]};
            end
            issue(i_type_word(opcodes[i], rs, rt, imms[j]), wb_idle);
            check_id_ex(id_ex_o, expected_bundle(cls, alu[i], rt, reg_value(rs), ext),
                        "immediate form");
        end
    end
endtask

task automatic shift_ops();
    logic [5:0] imm_funcs [3];
    logic [5:0] var_funcs [3];
    logic [7:0] alu [3];
    logic [4:0] sa;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    imm_funcs = '{id_pkg::func_sll, id_pkg::func_srl, id_pkg::func_sra};
    var_funcs = '{id_pkg::func_sllv, id_pkg::func_srlv, id_pkg::func_srav};
    alu       = '{id_pkg::alu_sll, id_pkg::alu_srl, id_pkg::alu_sra};
    for (int i = 0; i < 3; i++) begin
        sa = 5'(7 + 8 * i);
        rt = 5'(9 + i);
        rd = 5'(4 + i);
        issue(r_type_word(imm_funcs[i], 5'd0, rt, rd, sa), wb_idle);
        check_id_ex(id_ex_o, expected_bundle(id_pkg::res_shift, alu[i], rd, reg_value(rt),
                    {27'd0, sa}), "immediate shift");
        rs = 5'(3 + i);
        rt = 5'(12 + i);
        rd = 5'(20 + i);
        issue(r_type_word(var_funcs[i], rs, rt, rd, 5'd0), wb_idle);
        check_id_ex(id_ex_o, expected_bundle(id_pkg::res_shift, alu[i], rd, reg_value(rt),
                    reg_value(rs)), "variable shift");
    end
endtask

task automatic write_forwarding();
    logic [31:0] fresh;
    id_pkg::wb_t wb;
    rng_state = xorshift32(rng_state);
    fresh     = rng_state;
    wb        = '{we: 1'b1, addr: 5'd7, data: fresh};
    issue(r_type_word(id_pkg::func_add, 5'd7, 5'd7, 5'd8, 5'd0), wb);
    shadow[7] = fresh;
    check_id_ex(id_ex_o, expected_bundle(id_pkg::res_arith, id_pkg::alu_add, 5'd8, fresh,
                fresh), "write-through");
    // writes to r0 are dropped so nothing is forwarded
    wb = '{we: 1'b1, addr: 5'd0, data: ~fresh};
    issue(r_type_word(id_pkg::func_or, 5'd0, 5'd0, 5'd11, 5'd0), wb);
    check_id_ex(id_ex_o, expected_bundle(id_pkg::res_logic, id_pkg::alu_or, 5'd11, 32'd0,
                32'd0), "write to r0");
    issue(r_type_word(id_pkg::func_xor, 5'd7, 5'd2, 5'd13, 5'd0), wb_idle);
    check_id_ex(id_ex_o, expected_bundle(id_pkg::res_logic, id_pkg::alu_xor, 5'd13,
                reg_value(5'd7), reg_value(5'd2)), "read after write");
endtask

task automatic no_op_words();
    issue('0, wb_idle);
    check_id_ex(id_ex_o, empty_bundle, "nop");
    check_bit(inst_invalid_o, 1'b0, "inst_invalid_o");
    issue(r_type_word(id_pkg::func_sync, 5'd0, 5'd0, 5'd0, 5'd0), wb_idle);
    check_id_ex(id_ex_o, empty_bundle, "sync");
    check_bit(inst_invalid_o, 1'b0, "inst_invalid_o");
    // opcode 6'b111111 is not decoded
    issue(i_type_word(6'b111111, 5'd3, 5'd4, 16'h1234), wb_idle);
    check_id_ex(id_ex_o, empty_bundle, "unknown opcode");
    check_bit(inst_invalid_o, 1'b1, "inst_invalid_o");
    issue('0, wb_idle);
    check_bit(inst_invalid_o, 1'b0, "inst_invalid_o");
endtask

`endif

// File: tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 5;
    localparam int fill_cycles   = id_pkg::reg_count - 1;
    // register forms 12, immediates 16, shifts 6, write-through 3, no-ops 4
    localparam int decode_cycles = 41;
    localparam int margin_cycles = 20;
    localparam int test_cycles   = reset_cycles + fill_cycles + decode_cycles;

    logic           clk;
    logic           arst_n_i;
    id_pkg::inst_u  inst_i;
    id_pkg::wb_t    wb_i;
    id_pkg::id_ex_t id_ex_o;
    logic           inst_invalid_o;

    logic [id_pkg::data_w-1:0] shadow [id_pkg::reg_count];
    logic [31:0]               rng_state;

    `include "tb_id_tasks.svh"

    id_stage UUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inst_i         (inst_i),
        .wb_i           (wb_i),
        .id_ex_o        (id_ex_o),
        .inst_invalid_o (inst_invalid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("watchdog timeout, the test sequence did not finish in time");
        fail_run();
    end

    initial begin
        arst_n_i  = 1'b0;
        inst_i    = '0;
        wb_i      = '0;
        rng_state = 32'h9a8f;
        shadow    = '{default: '0};
        repeat (reset_cycles) @(negedge clk);
        arst_n_i = 1'b1;

        reset_values();
        fill_registers();
        reg_form_ops();
        imm_form_ops();
        shift_ops();
        write_forwarding();
        no_op_words();

        $display("Test passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
id_pkg.sv
inst_decoder.sv
operand_sel.sv
regfile.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ID stage testbench, exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -f sources.f -o sim_id_stage

./obj_dir/sim_id_stage
